//--- compile.f
nnTypesPkg.sv
nnMemPkg.sv
weightBus.sv
weightStore.sv
weightArbiter.sv
neuronUnit.sv
denseLayer.sv
tbClock.sv
denseLayerTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= denseLayerTb
FILELIST ?= compile.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- denseLayerTb.sv
`timescale 1ns/1ps

module denseLayerTb;
	import nnTypesPkg::*;
	import nnMemPkg::*;

	localparam int periodNs = 20;
	localparam int resetCycles = 10;
	localparam int idleCycles = 20; // cycles watched before the first start.
	localparam int quietCycles = 20; // cycles watched after the last done.
	localparam int randomRuns = 5;
	localparam int runCount = 4 + randomRuns; // store loads over the whole run.
	localparam int readBound = wordsPerNeuron * nNeurons * 2;
	localparam int runLimit = readBound + 64; // longest wait for all done pulses.
	localparam int runCycles = memDepth + runLimit + quietCycles + 8;
	localparam int watchdogCycles = resetCycles + idleCycles + runCount * runCycles + 100;

	localparam weight_t refWeights [nInputs] = '{
		16'sd3, -16'sd2, 16'sd5, 16'sd1, -16'sd1, 16'sd4, 16'sd2, -16'sd3,
		16'sd1, 16'sd6, -16'sd2, 16'sd2, 16'sd1, -16'sd4, 16'sd3
	};

	logic clk;
	logic reset;
	logic wrEn;
	weightAddr_t wrAddr;
	weight_t wrData;
	logic start;
	activationVec_t activations;
	outputVec_t neuronOut;
	logic [nNeurons-1:0] neuronDone;

	weight_t weightImg [memDepth]; // image of the store as the model sees it.
	activation_t actVal [nInputs]; // activations the results must follow.

	tbClock #(
		.periodNs(periodNs),
		.resetCycles(resetCycles)
	) uClock (
		.clk(clk),
		.reset(reset)
	);

	denseLayer DUT (
		.clk(clk),
		.reset(reset),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.start(start),
		.activations(activations),
		.neuronOut(neuronOut),
		.neuronDone(neuronDone)
	);

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "run stopped on the first error");
	endtask

	// products keep their low 16 bits, the sum wraps, a negative sum becomes zero.
	function automatic activation_t expectedOut(input int n);
		logic [dataWidth-1:0] sum;
		int prod;
		int base;
		base = n * wordsPerNeuron;
		sum = '0;
		for (int k = 0; k < nInputs; k++)
		begin
			prod = int'(actVal[k]) * int'(weightImg[base + k]);
			sum = sum + prod[dataWidth-1:0];
		end
		sum = sum + weightImg[base + biasOffset];
		if (sum[dataWidth-1])
		begin
			expectedOut = '0;
		end
		else
		begin
			expectedOut = activation_t'(sum);
		end
	endfunction

	function automatic activationVec_t packActivations();
		activationVec_t v;
		for (int k = 0; k < nInputs; k++)
		begin
			v[k*dataWidth +: dataWidth] = actVal[k];
		end
		return v;
	endfunction

	task automatic loadStore();
		for (int a = 0; a < memDepth; a++)
		begin
			wrEn = 1'b1;
			wrAddr = weightAddr_t'(a);
			wrData = weightImg[a];
			@(negedge clk);
		end
		wrEn = 1'b0;
	endtask

	// a negative restartAt means no second start is given.
	task automatic runLayer(input int restartAt);
		int doneCnt [nNeurons];
		int cycles;
		int quiet;
		bit allDone;
		for (int n = 0; n < nNeurons; n++)
		begin
			doneCnt[n] = 0;
		end
		activations = packActivations();
		start = 1'b1;
		@(negedge clk);
		cycles = 0;
		quiet = 0;
		while (quiet < quietCycles)
		begin
			allDone = 1'b1;
			for (int n = 0; n < nNeurons; n++)
			begin
				if (neuronDone[n])
				begin
					doneCnt[n]++;
				end
				if (doneCnt[n] == 0)
				begin
					allDone = 1'b0;
				end
			end
			start = (cycles == restartAt);
			if (cycles == restartAt)
			begin
				activations = ~packActivations(); // must not reach the busy neurons.
			end
			if (allDone)
			begin
				quiet++;
			end
			if (cycles > runLimit)
			begin
				failRun("timeout: not every neuron signalled done after start");
			end
			cycles++;
			@(negedge clk);
		end
		for (int n = 0; n < nNeurons; n++)
		begin
			assert (doneCnt[n] == 1)
			else failRun($sformatf("ERR %0t: neuron %0d gave %0d done pulses, expected 1",
				$time, n, doneCnt[n]));
		end
	endtask

	task automatic checkOutputs();
		activation_t got;
		activation_t exp;
		for (int n = 0; n < nNeurons; n++)
		begin
			got = neuronOut[n*dataWidth +: dataWidth];
			exp = expectedOut(n);
			assert (got == exp)
			else failRun($sformatf("ERR %0t: neuron %0d output %h, expected %h",
				$time, n, got, exp));
		end
	endtask

	task automatic resetIdleTest();
		@(negedge clk);
		while (reset)
		begin
			@(negedge clk);
		end
		repeat (idleCycles)
		begin
			assert (neuronDone == '0 && neuronOut == '0)
			else failRun($sformatf("ERR %0t: done %b output %h before any start",
				$time, neuronDone, neuronOut));
			@(negedge clk);
		end
	endtask

	task automatic referenceNodeTest();
		for (int n = 0; n < nNeurons; n++)
		begin
			for (int k = 0; k < nInputs; k++)
			begin
				weightImg[n*wordsPerNeuron + k] = refWeights[(k + n) % nInputs];
			end
			weightImg[n*wordsPerNeuron + biasOffset] = weight_t'(-4);
		end
		for (int k = 0; k < nInputs; k++)
		begin
			actVal[k] = activation_t'(k + 1);
		end
		loadStore();
		runLayer(-1);
		checkOutputs();
	endtask

	task automatic negativeSumTest();
		for (int n = 0; n < nNeurons; n++)
		begin
			for (int k = 0; k < nInputs; k++)
			begin
				weightImg[n*wordsPerNeuron + k] = weight_t'(-(k + n + 1));
			end
			weightImg[n*wordsPerNeuron + biasOffset] = weight_t'(-2);
		end
		for (int k = 0; k < nInputs; k++)
		begin
			actVal[k] = activation_t'(k + 1);
		end
		loadStore();
		runLayer(-1);
		checkOutputs();
		assert (neuronOut == '0)
		else failRun($sformatf("ERR %0t: rectifier passed %h", $time, neuronOut));
	endtask

	task automatic wrapAroundTest();
		for (int n = 0; n < nNeurons; n++)
		begin
			for (int k = 0; k < nInputs; k++)
			begin
				weightImg[n*wordsPerNeuron + k] = weight_t'(16'h5a00 - (k + n) * 16'h0203);
			end
			weightImg[n*wordsPerNeuron + biasOffset] = weight_t'(16'h4000 + n);
		end
		for (int k = 0; k < nInputs; k++)
		begin
			actVal[k] = activation_t'(16'h7000 + k * 16'h0111);
		end
		loadStore();
		runLayer(-1);
		checkOutputs();
	endtask

	task automatic randomFill();
		for (int a = 0; a < memDepth; a++)
		begin
			weightImg[a] = weight_t'($urandom());
		end
		for (int k = 0; k < nInputs; k++)
		begin
			actVal[k] = activation_t'($urandom());
		end
	endtask

	task automatic contentionTest();
		for (int r = 0; r < randomRuns; r++)
		begin
			randomFill();
			loadStore();
			runLayer(-1);
			checkOutputs();
		end
	endtask

	task automatic restartWhileBusyTest();
		randomFill();
		loadStore();
		runLayer(5); // second start arrives a few cycles into the fetches.
		checkOutputs();
	endtask

	initial
	begin
		wrEn = 1'b0;
		wrAddr = '0;
		wrData = '0;
		start = 1'b0;
		activations = '0;
		void'($urandom(32'hde69));
		resetIdleTest();
		referenceNodeTest();
		negativeSumTest();
		wrapAroundTest();
		contentionTest();
		restartWhileBusyTest();
		$display("sim passed");
		$finish;
	end

	initial
	begin
		#(watchdogCycles * periodNs);
		failRun("timeout: the tests ran longer than their worst-case length");
	end

endmodule

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter int periodNs = 20,
	parameter int resetCycles = 10
) (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

	// release on a falling edge so the DUT never sees reset change at its sampling edge.
	initial
	begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

//--- denseLayer.sv
`timescale 1ns/1ps

module denseLayer (
	input logic clk,
	input logic reset,
	input logic wrEn,
	input nnMemPkg::weightAddr_t wrAddr,
	input nnTypesPkg::weight_t wrData,
	input logic start,
	input nnTypesPkg::activationVec_t activations,
	output nnTypesPkg::outputVec_t neuronOut,
	output logic [nnTypesPkg::nNeurons-1:0] neuronDone
);
	import nnTypesPkg::*;

	weightBus clientBus [nNeurons] (); // one read port per neuron.
	weightBus memBus (); // arbitrated port into the store.

	genvar i;
	generate
		for (i = 0; i < nNeurons; i++)
		begin : gNeuron
			neuronUnit #(
				.neuronIndex(i)
			) uNeuron (
				.clk(clk),
				.reset(reset),
				.start(start),
				.activations(activations),
				.wb(clientBus[i]),
				.result(neuronOut[i*dataWidth +: dataWidth]),
				.done(neuronDone[i])
			);
		end
	endgenerate

	weightArbiter uArbiter (
		.clk(clk),
		.reset(reset),
		.clients(clientBus),
		.mem(memBus)
	);

	weightStore uStore (
		.clk(clk),
		.reset(reset),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rd(memBus)
	);

endmodule

//--- neuronUnit.sv
`timescale 1ns/1ps

module neuronUnit #(
	parameter int neuronIndex = 0
) (
	input logic clk,
	input logic reset,
	input logic start,
	input nnTypesPkg::activationVec_t activations,
	weightBus.requester wb,
	output nnTypesPkg::activation_t result,
	output logic done
);
	import nnTypesPkg::*;
	import nnMemPkg::*;

	typedef enum logic [1:0] {
		idle,
		request,
		waitData,
		finish
	} state_t;

	state_t state;
	wordSel_t wordCnt; // word of this neuron's block being fetched.
	activation_t acc; // running sum, wraps at dataWidth bits.
	activation_t actQ [nInputs]; // latched activations, current one at index 0.
	activation_t addend;
	logic lastWord;
	logic startAccepted;
	logic wordArrived;

	assign startAccepted = (state == idle) && start;
	assign wordArrived = (state == waitData) && wb.rdValid;
	assign lastWord = (wordCnt == wordSel_t'(biasOffset));

	// the product keeps only its low dataWidth bits.
	assign addend = lastWord ? wb.rdData : activation_t'(actQ[0] * wb.rdData);

	assign wb.req = (state == request);
	assign wb.addr = wordAddr(blockSel_t'(neuronIndex), wordCnt);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			wordCnt <= '0;
			result <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				idle:
				begin
					if (start)
					begin
						wordCnt <= '0;
						state <= request;
					end
				end
				request:
				begin
					if (wb.gnt)
					begin
						state <= waitData; // address was taken this cycle.
					end
				end
				waitData:
				begin
					if (wb.rdValid)
					begin
						if (lastWord)
						begin
							state <= finish; // bias has been added.
						end
						else
						begin
							wordCnt <= wordCnt + 1'b1;
							state <= request;
						end
					end
				end
				finish:
				begin
					result <= acc[dataWidth-1] ? '0 : acc; // rectifier.
					done <= 1'b1;
					state <= idle;
				end
				default:
				begin
					state <= idle;
				end
			endcase
		end
	end

	// the activations shift down one place for each weight consumed.
	always_ff @(posedge clk)
	begin
		if (startAccepted)
		begin
			acc <= '0;
			for (int k = 0; k < nInputs; k++)
			begin
				actQ[k] <= activations[k*dataWidth +: dataWidth];
			end
		end
		else if (wordArrived)
		begin
			acc <= acc + addend;
			for (int k = 0; k < nInputs - 1; k++)
			begin
				actQ[k] <= actQ[k+1];
			end
		end
	end

endmodule

//--- weightArbiter.sv
`timescale 1ns/1ps

module weightArbiter (
	input logic clk,
	input logic reset,
	weightBus.server clients [nnTypesPkg::nNeurons],
	weightBus.requester mem
);
	import nnTypesPkg::*;
	import nnMemPkg::*;

	logic [nNeurons-1:0] reqVec;
	weightAddr_t addrVec [nNeurons];
	logic [nNeurons-1:0] gntVec;
	neuronId_t rrPtr; // first client to be considered this cycle.
	neuronId_t winner;
	logic winnerFound;
	logic accepted;
	neuronId_t ownerQ; // client whose read is in the store pipeline.

	genvar i;
	generate
		for (i = 0; i < nNeurons; i++)
		begin : gClient
			assign reqVec[i] = clients[i].req;
			assign addrVec[i] = clients[i].addr;
			assign gntVec[i] = accepted && (winner == neuronId_t'(i));
			assign clients[i].gnt = gntVec[i];
			assign clients[i].rdData = mem.rdData; // only the owner sees rdValid.
			assign clients[i].rdValid = mem.rdValid && (ownerQ == neuronId_t'(i));
		end
	endgenerate

	// search the requesters starting at the pointer, wrapping around once.
	always_comb
	begin
		winner = rrPtr;
		winnerFound = 1'b0;
		for (int k = 0; k < nNeurons; k++)
		begin
			neuronId_t cand;
			cand = neuronId_t'(rrPtr + k);
			if (!winnerFound && reqVec[cand])
			begin
				winner = cand;
				winnerFound = 1'b1;
			end
		end
	end

	assign accepted = winnerFound && mem.gnt;
	assign mem.req = winnerFound;
	assign mem.addr = addrVec[winner];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rrPtr <= '0;
			ownerQ <= '0;
		end
		else if (accepted)
		begin
			rrPtr <= winner + 1'b1; // the next search starts after the winner.
			ownerQ <= winner;
		end
	end

endmodule

//--- weightStore.sv
`timescale 1ns/1ps

module weightStore (
	input logic clk,
	input logic reset,
	input logic wrEn,
	input nnMemPkg::weightAddr_t wrAddr,
	input nnTypesPkg::weight_t wrData,
	weightBus.server rd
);
	import nnTypesPkg::*;
	import nnMemPkg::*;

	weight_t mem [memDepth]; // weights and biases of all neurons.
	logic rdValidQ;
	weight_t rdDataQ;

	// the store never stalls, so every requested read is accepted.
	assign rd.gnt = 1'b1;
	assign rd.rdData = rdDataQ;
	assign rd.rdValid = rdValidQ;

	// write port. the registered read below sees the old word on a collision.
	always_ff @(posedge clk)
	begin
		if (wrEn)
		begin
			mem[wrAddr] <= wrData;
		end
	end

	// read port, one cycle from address to data.
	always_ff @(posedge clk)
	begin
		if (rd.req)
		begin
			rdDataQ <= mem[rd.addr];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rdValidQ <= 1'b0;
		end
		else
		begin
			rdValidQ <= rd.req && rd.gnt; // data follows every accepted read.
		end
	end

endmodule

//--- weightBus.sv
`timescale 1ns/1ps

interface weightBus;
	import nnTypesPkg::*;
	import nnMemPkg::*;

	logic req; // held high until gnt is seen.
	weightAddr_t addr; // held steady together with req.
	logic gnt; // marks the cycle in which the read is accepted.
	weight_t rdData; // read word, valid with rdValid.
	logic rdValid; // one cycle after the accepted read.

	modport requester (
		output req,
		output addr,
		input gnt,
		input rdData,
		input rdValid
	);

	modport server (
		input req,
		input addr,
		output gnt,
		output rdData,
		output rdValid
	);

endinterface

//--- nnMemPkg.sv
package nnMemPkg;

	// each neuron owns one block of the store.
	localparam int wordsPerNeuron = 16; // fifteen weights followed by the bias.
	localparam int biasOffset = 15; // the bias is the last word of a block.
	localparam int memDepth = 64;

	localparam int addrWidth = $clog2(memDepth);
	localparam int wordSelWidth = $clog2(wordsPerNeuron);
	localparam int blockSelWidth = addrWidth - wordSelWidth;

	// upper bits pick the neuron block, lower bits pick the word in it.
	typedef logic [addrWidth-1:0] weightAddr_t;

	// word position inside one neuron block.
	typedef logic [wordSelWidth-1:0] wordSel_t;

	// neuron block number as it appears in the upper address bits.
	typedef logic [blockSelWidth-1:0] blockSel_t;

	// builds the store address of one word in one neuron block.
	function automatic weightAddr_t wordAddr(input blockSel_t block, input wordSel_t word);
		return {block, word};
	endfunction

endpackage

//--- nnTypesPkg.sv
package nnTypesPkg;

	// number format shared by the whole layer.
	localparam int dataWidth = 16; // activations, weights, products and sums.

	// layer size.
	localparam int nInputs = 15; // activations feeding each neuron.
	localparam int nNeurons = 4; // neuron units sharing the weight store.
	localparam int neuronIdWidth = $clog2(nNeurons);

	// derived vector widths for the packed ports.
	localparam int activationVecWidth = nInputs * dataWidth;
	localparam int outputVecWidth = nNeurons * dataWidth;

	// one two's-complement activation or neuron output.
	typedef logic signed [dataWidth-1:0] activation_t;

	// one two's-complement weight or bias word.
	typedef logic signed [dataWidth-1:0] weight_t;

	// activation 0 sits in the lowest bits.
	typedef logic [activationVecWidth-1:0] activationVec_t;

	// neuron 0 sits in the lowest bits.
	typedef logic [outputVecWidth-1:0] outputVec_t;

	// index of one neuron unit.
	typedef logic [neuronIdWidth-1:0] neuronId_t;

endpackage
